/* rtl/image_pkg.sv */
// image geometry and load port shape
package image_pkg;

	// default image side, pixels per row and per column
	localparam int DEFAULT_IMG_DIM = 20;

	// default pixel depth in bits
	localparam int DEFAULT_PIX_W = 5;

	// pixels written per accepted load beat
	// tied to the five pixel_in ports, so not a module parameter
	localparam int LOAD_LANES = 5;

endpackage

/* rtl/scan_pkg.sv */
// window scan definitions
package scan_pkg;

	// window side, also rows per column read and number of column sorters
	localparam int WIN_SIZE = 3;

	// controller state
	typedef enum logic [1:0] {
		scan_load, // accepting pixels into the frame buffer
		scan_run   // issuing window column reads
	} scan_state_t;

endpackage

/* rtl/frame_buffer.sv */
`timescale 1ns/10ps

module frame_buffer #(
	parameter int IMG_DIM = image_pkg::DEFAULT_IMG_DIM,
	parameter int PIX_W = image_pkg::DEFAULT_PIX_W,
	localparam int ADDR_W = $clog2(IMG_DIM * IMG_DIM),
	localparam int IDX_W = $clog2(IMG_DIM)
) (
	input  logic clk,
	input  logic write_en,
	input  logic [ADDR_W-1:0] write_base, // index of lane 0 pixel
	input  logic [image_pkg::LOAD_LANES-1:0][PIX_W-1:0] write_pixels,
	input  logic [IDX_W-1:0] read_row, // top row of the column
	input  logic [IDX_W-1:0] read_col,
	output logic [scan_pkg::WIN_SIZE-1:0][PIX_W-1:0] read_column // [0] is the top pixel
);

	import image_pkg::*;
	import scan_pkg::*;

	localparam int PIX_CNT = IMG_DIM * IMG_DIM;

	logic [PIX_W-1:0] mem [PIX_CNT]; // raster order image
	logic [ADDR_W-1:0] read_addr; // raster index of the top pixel

	assign read_addr = ADDR_W'(read_row) * ADDR_W'(IMG_DIM) + ADDR_W'(read_col);

	// five lanes land on adjacent entries
	always_ff @(posedge clk) begin
		if (write_en) begin
			for (int i = 0; i < LOAD_LANES; i++) begin
				mem[write_base + ADDR_W'(i)] <= write_pixels[i];
			end
		end
	end

	// vertical strip, one row stride apart
	always_ff @(posedge clk) begin
		for (int r = 0; r < WIN_SIZE; r++) begin
			read_column[r] <= mem[read_addr + ADDR_W'(r * IMG_DIM)];
		end
	end

	// a full beat never runs past the last pixel
	// scanner counter and load_end placement both have to be right for this
	a_write_in_range: assert property (@(posedge clk)
		write_en |-> ({1'b0, write_base} + (ADDR_W + 1)'(LOAD_LANES)) <= (ADDR_W + 1)'(PIX_CNT))
		else $error("frame buffer write beyond image at base %0d", write_base);

endmodule

/* rtl/window_scanner.sv */
`timescale 1ns/10ps

module window_scanner #(
	parameter int IMG_DIM = image_pkg::DEFAULT_IMG_DIM,
	parameter int PIX_W = image_pkg::DEFAULT_PIX_W,
	localparam int ADDR_W = $clog2(IMG_DIM * IMG_DIM),
	localparam int IDX_W = $clog2(IMG_DIM)
) (
	input  logic clk,
	input  logic reset,
	input  logic pixel_valid,
	input  logic load_end, // with the final beat of an image
	output logic load_ready,
	output logic write_en,
	output logic [ADDR_W-1:0] write_base,
	output logic [IDX_W-1:0] read_row,
	output logic [IDX_W-1:0] read_col,
	input  logic [scan_pkg::WIN_SIZE-1:0][PIX_W-1:0] read_column,
	output logic [scan_pkg::WIN_SIZE-1:0][scan_pkg::WIN_SIZE-1:0][PIX_W-1:0] window,
	output logic window_valid,
	output logic window_last
);

	import image_pkg::*;
	import scan_pkg::*;

	localparam int LAST_ROW = IMG_DIM - WIN_SIZE; // top row of the final band

	scan_state_t state;
	logic beat; // accepted load beat
	logic col_end; // last column of the current row band
	logic last_read; // final read of the frame
	logic data_valid; // read_column carries a real column
	logic data_last;
	logic [IDX_W-1:0] data_col; // column of the data now on read_column

	assign load_ready = (state == scan_load);
	assign beat = pixel_valid && load_ready;
	assign write_en = beat; // buffer writes every accepted beat
	assign col_end = (read_col == IDX_W'(IMG_DIM - 1));
	assign last_read = (state == scan_run) && col_end && (read_row == IDX_W'(LAST_ROW));

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= scan_load;
			write_base <= '0;
			read_row <= '0;
			read_col <= '0;
		end else begin
			case (state)
				scan_load: begin
					if (beat) begin
						write_base <= write_base + ADDR_W'(LOAD_LANES); // next five pixels
						if (load_end) begin
							state <= scan_run; // reads start next cycle
						end
					end
				end
				scan_run: begin
					if (col_end) begin
						read_col <= '0;
						if (last_read) begin
							// whole frame read, buffer free for the next image
							read_row <= '0;
							write_base <= '0;
							state <= scan_load;
						end else begin
							read_row <= read_row + 1'b1; // next band
						end
					end else begin
						read_col <= read_col + 1'b1;
					end
				end
				default: state <= scan_load;
			endcase
		end
	end

	// address tags delayed to line up with the buffer read data
	always_ff @(posedge clk) begin
		if (reset) begin
			data_valid <= 1'b0;
			data_last <= 1'b0;
			data_col <= '0;
			window_valid <= 1'b0;
			window_last <= 1'b0;
		end else begin
			data_valid <= (state == scan_run);
			data_last <= last_read;
			data_col <= read_col;
			// full window only after the third column of a band
			window_valid <= data_valid && (data_col >= IDX_W'(WIN_SIZE - 1));
			window_last <= data_valid && data_last;
		end
	end

	// window shift, oldest column at [0]
	always_ff @(posedge clk) begin
		if (data_valid) begin
			for (int c = 0; c < WIN_SIZE - 1; c++) begin
				window[c] <= window[c + 1];
			end
			window[WIN_SIZE-1] <= read_column;
		end
	end

	// a source must not mark a frame end on an idle cycle
	a_load_end_qualified: assert property (@(posedge clk) disable iff (reset)
		(load_ready && load_end) |-> pixel_valid)
		else $error("load_end seen without pixel_valid");

endmodule

/* rtl/column_sorter.sv */
`timescale 1ns/10ps

module column_sorter #(
	parameter int PIX_W = image_pkg::DEFAULT_PIX_W
) (
	input  logic clk,
	input  logic reset,
	input  logic [2:0][PIX_W-1:0] col_in, // one window column
	input  logic in_valid,
	input  logic in_last,
	output logic [PIX_W-1:0] col_min,
	output logic [PIX_W-1:0] col_mid,
	output logic [PIX_W-1:0] col_max,
	output logic sort_valid,
	output logic sort_last
);

	logic [PIX_W-1:0] lo_ab, hi_ab; // first compare-swap
	logic [PIX_W-1:0] hi_c; // larger of lo_ab and col_in[2]
	logic [PIX_W-1:0] min_w, mid_w, max_w;

	// three compare-swaps
	always_comb begin
		lo_ab = (col_in[0] < col_in[1]) ? col_in[0] : col_in[1];
		hi_ab = (col_in[0] < col_in[1]) ? col_in[1] : col_in[0];
		min_w = (lo_ab < col_in[2]) ? lo_ab : col_in[2];
		hi_c = (lo_ab < col_in[2]) ? col_in[2] : lo_ab;
		mid_w = (hi_c < hi_ab) ? hi_c : hi_ab;
		max_w = (hi_c < hi_ab) ? hi_ab : hi_c;
	end

	always_ff @(posedge clk) begin
		col_min <= min_w;
		col_mid <= mid_w;
		col_max <= max_w;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sort_valid <= 1'b0;
			sort_last <= 1'b0;
		end else begin
			sort_valid <= in_valid;
			sort_last <= in_valid && in_last; // last only rides a valid column
		end
	end

	a_sorted: assert property (@(posedge clk) disable iff (reset)
		sort_valid |-> (col_min <= col_mid) && (col_mid <= col_max))
		else $error("column sort out of order");

endmodule

/* rtl/median_merge.sv */
`timescale 1ns/10ps

module median_merge #(
	parameter int PIX_W = image_pkg::DEFAULT_PIX_W
) (
	input  logic clk,
	input  logic reset,
	input  logic [scan_pkg::WIN_SIZE-1:0][PIX_W-1:0] col_min, // per sorted column
	input  logic [scan_pkg::WIN_SIZE-1:0][PIX_W-1:0] col_mid,
	input  logic [scan_pkg::WIN_SIZE-1:0][PIX_W-1:0] col_max,
	input  logic sort_valid,
	input  logic sort_last,
	output logic [PIX_W-1:0] median_out,
	output logic median_valid,
	output logic frame_done
);

	logic [PIX_W-1:0] max_of_min; // stage one results
	logic [PIX_W-1:0] med_of_mid;
	logic [PIX_W-1:0] min_of_max;
	logic s1_valid, s1_last;

	function automatic logic [PIX_W-1:0] max3(input logic [PIX_W-1:0] a, b, c);
		logic [PIX_W-1:0] m;
		m = (a > b) ? a : b;
		return (m > c) ? m : c;
	endfunction

	function automatic logic [PIX_W-1:0] min3(input logic [PIX_W-1:0] a, b, c);
		logic [PIX_W-1:0] m;
		m = (a < b) ? a : b;
		return (m < c) ? m : c;
	endfunction

	// max(min(a,b), min(max(a,b), c))
	function automatic logic [PIX_W-1:0] med3(input logic [PIX_W-1:0] a, b, c);
		logic [PIX_W-1:0] lo, hi, t;
		lo = (a < b) ? a : b;
		hi = (a < b) ? b : a;
		t = (hi < c) ? hi : c;
		return (lo > t) ? lo : t;
	endfunction

	always_ff @(posedge clk) begin
		max_of_min <= max3(col_min[0], col_min[1], col_min[2]);
		med_of_mid <= med3(col_mid[0], col_mid[1], col_mid[2]);
		min_of_max <= min3(col_max[0], col_max[1], col_max[2]);
		median_out <= med3(max_of_min, med_of_mid, min_of_max); // true 3x3 median
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s1_last <= 1'b0;
			median_valid <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			s1_valid <= sort_valid;
			s1_last <= sort_valid && sort_last;
			median_valid <= s1_valid;
			frame_done <= s1_valid && s1_last; // pulse with the final median
		end
	end

	a_done_with_result: assert property (@(posedge clk) disable iff (reset)
		frame_done |-> median_valid)
		else $error("frame_done without a median");

endmodule

/* rtl/image_median_top.sv */
`timescale 1ns/10ps

module image_median_top #(
	parameter int IMG_DIM = image_pkg::DEFAULT_IMG_DIM,
	parameter int PIX_W = image_pkg::DEFAULT_PIX_W
) (
	input  logic clk,
	input  logic reset,
	input  logic [PIX_W-1:0] pixel_in0, // lane 0, lowest index of the beat
	input  logic [PIX_W-1:0] pixel_in1,
	input  logic [PIX_W-1:0] pixel_in2,
	input  logic [PIX_W-1:0] pixel_in3,
	input  logic [PIX_W-1:0] pixel_in4,
	input  logic pixel_valid,
	input  logic load_end,
	output logic load_ready,
	output logic [PIX_W-1:0] median_out,
	output logic median_valid,
	output logic frame_done
);

	import scan_pkg::*;

	localparam int ADDR_W = $clog2(IMG_DIM * IMG_DIM);
	localparam int IDX_W = $clog2(IMG_DIM);

	logic write_en;
	logic [ADDR_W-1:0] write_base;
	logic [IDX_W-1:0] read_row, read_col;
	logic [WIN_SIZE-1:0][PIX_W-1:0] read_column;
	logic [WIN_SIZE-1:0][WIN_SIZE-1:0][PIX_W-1:0] window; // [column][row]
	logic window_valid, window_last;
	logic [WIN_SIZE-1:0][PIX_W-1:0] col_min, col_mid, col_max;
	logic [WIN_SIZE-1:0] sort_valid, sort_last; // one bit per sorter

	frame_buffer #(
		.IMG_DIM(IMG_DIM),
		.PIX_W(PIX_W)
	) frame_buffer0 (
		.clk(clk),
		.write_en(write_en),
		.write_base(write_base),
		.write_pixels({pixel_in4, pixel_in3, pixel_in2, pixel_in1, pixel_in0}),
		.read_row(read_row),
		.read_col(read_col),
		.read_column(read_column)
	);

	window_scanner #(
		.IMG_DIM(IMG_DIM),
		.PIX_W(PIX_W)
	) window_scanner0 (
		.clk(clk),
		.reset(reset),
		.pixel_valid(pixel_valid),
		.load_end(load_end),
		.load_ready(load_ready),
		.write_en(write_en),
		.write_base(write_base),
		.read_row(read_row),
		.read_col(read_col),
		.read_column(read_column),
		.window(window),
		.window_valid(window_valid),
		.window_last(window_last)
	);

	// one sorter per window column, all in lock step
	for (genvar c = 0; c < WIN_SIZE; c++) begin : g_sorter
		column_sorter #(
			.PIX_W(PIX_W)
		) column_sorter0 (
			.clk(clk),
			.reset(reset),
			.col_in(window[c]),
			.in_valid(window_valid),
			.in_last(window_last),
			.col_min(col_min[c]),
			.col_mid(col_mid[c]),
			.col_max(col_max[c]),
			.sort_valid(sort_valid[c]),
			.sort_last(sort_last[c])
		);
	end

	median_merge #(
		.PIX_W(PIX_W)
	) median_merge0 (
		.clk(clk),
		.reset(reset),
		.col_min(col_min),
		.col_mid(col_mid),
		.col_max(col_max),
		.sort_valid(&sort_valid), // sorters share timing, so bits agree
		.sort_last(&sort_last),
		.median_out(median_out),
		.median_valid(median_valid),
		.frame_done(frame_done)
	);

endmodule

/* verification/tb_image_median_top.sv */
`timescale 1ns/10ps

module tb_image_median_top;

	import image_pkg::*;
	import scan_pkg::*;

	localparam int IMG_DIM = DEFAULT_IMG_DIM;
	localparam int PIX_W = DEFAULT_PIX_W;
	localparam int PIX_CNT = IMG_DIM * IMG_DIM;
	localparam int BEATS = PIX_CNT / LOAD_LANES; // 80 beats per frame
	localparam int OUT_DIM = IMG_DIM - WIN_SIZE + 1; // 18 windows per row
	localparam int RESULTS = OUT_DIM * OUT_DIM;
	localparam int SCAN_CYCLES = OUT_DIM * IMG_DIM; // one read per column per band
	localparam int WIN_CNT = WIN_SIZE * WIN_SIZE;
	localparam int WAIT_LIMIT = 2000; // cycles before a wait gives up
	localparam int EXP_DEPTH = 2048; // room for every frame of the run

	logic clk;
	logic reset;
	logic [PIX_W-1:0] pixel_in0, pixel_in1, pixel_in2, pixel_in3, pixel_in4;
	logic pixel_valid;
	logic load_end;
	logic load_ready;
	logic [PIX_W-1:0] median_out;
	logic median_valid;
	logic frame_done;

	logic [31:0] lfsr;
	logic [PIX_W-1:0] img [PIX_CNT]; // image being sent, raster order
	logic [PIX_W-1:0] exp_mem [EXP_DEPTH]; // expected medians of all frames
	logic [PIX_W-1:0] exp_now; // expected value of the next result
	logic [PIX_W-1:0] background;
	int wr_ptr, rd_ptr;
	int frame_strobes; // results so far in the current frame
	int done_cnt;
	int busy_cnt; // cycles load_ready has been low
	int frames_sent;
	int err_cnt, test_start_errs, tests_run, tests_failed;
	bit run_ok;
	bit flat_check; // impulse frame in flight
	string test_name;

	image_median_top dut0 (
		.clk(clk),
		.reset(reset),
		.pixel_in0(pixel_in0),
		.pixel_in1(pixel_in1),
		.pixel_in2(pixel_in2),
		.pixel_in3(pixel_in3),
		.pixel_in4(pixel_in4),
		.pixel_valid(pixel_valid),
		.load_end(load_end),
		.load_ready(load_ready),
		.median_out(median_out),
		.median_valid(median_valid),
		.frame_done(frame_done)
	);

	always #20 clk = ~clk;

	assign exp_now = exp_mem[rd_ptr];

	// result and handshake bookkeeping for the assertions
	always @(posedge clk) begin
		if (reset) begin
			rd_ptr <= 0;
			frame_strobes <= 0;
			done_cnt <= 0;
			busy_cnt <= 0;
		end else begin
			if (median_valid) begin
				rd_ptr <= rd_ptr + 1;
				// restart per frame
				frame_strobes <= (frame_strobes == RESULTS - 1) ? 0 : frame_strobes + 1;
			end
			if (frame_done) begin
				done_cnt <= done_cnt + 1;
			end
			busy_cnt <= load_ready ? 0 : busy_cnt + 1;
		end
	end

	a_reset_state: assert property (@(posedge clk)
		reset |=> load_ready && !median_valid && !frame_done)
		else begin
			$display("reset left load_ready low or a result strobe high");
			err_cnt++;
		end

	// raster order results against the reference model
	a_median_value: assert property (@(posedge clk) disable iff (reset)
		median_valid |-> median_out == exp_now)
		else begin
			$display("FAIL %s result %0d expected %0d actual %0d", test_name,
				$sampled(frame_strobes), $sampled(exp_now), $sampled(median_out));
			err_cnt++;
		end

	// frame_done only with the 324th strobe
	a_done_on_last: assert property (@(posedge clk) disable iff (reset)
		median_valid |-> frame_done == (frame_strobes == RESULTS - 1))
		else begin
			$display("FAIL %s frame_done at result %0d expected %0d actual %0d", test_name,
				$sampled(frame_strobes), $sampled(frame_strobes == RESULTS - 1),
				$sampled(frame_done));
			err_cnt++;
		end

	a_busy_after_load: assert property (@(posedge clk) disable iff (reset)
		(pixel_valid && load_ready && load_end) |=> !load_ready)
		else begin
			$display("load_ready stayed high after the load_end beat in %s", test_name);
			err_cnt++;
		end

	// low for exactly the read phase of the scan
	a_busy_length: assert property (@(posedge clk) disable iff (reset)
		$rose(load_ready) |-> busy_cnt == SCAN_CYCLES)
		else begin
			$display("FAIL %s busy cycles expected %0d actual %0d", test_name,
				SCAN_CYCLES, $sampled(busy_cnt));
			err_cnt++;
		end

	// scan only ever starts from an accepted load_end beat
	a_scan_from_load_end: assert property (@(posedge clk) disable iff (reset)
		$rose(dut0.window_scanner0.state == scan_run)
			|-> $past(pixel_valid && load_ready && load_end))
		else begin
			$display("scanner started a scan without a load_end beat in %s", test_name);
			err_cnt++;
		end

	// isolated impulses never survive the filter
	a_flat_result: assert property (@(posedge clk) disable iff (reset)
		(flat_check && median_valid) |-> median_out == background)
		else begin
			$display("FAIL %s background expected %0d actual %0d", test_name,
				$sampled(background), $sampled(median_out));
			err_cnt++;
		end

	// galois form, one shift per bit
	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) begin
			lfsr = lfsr ^ 32'h80200003;
		end
		return b;
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr_bit()};
		end
		return v;
	endfunction

	// plain sort of the nine neighbors, middle entry
	function automatic logic [PIX_W-1:0] ref_median(input int row, input int col);
		logic [PIX_W-1:0] v [WIN_CNT];
		logic [PIX_W-1:0] t;
		int j;
		for (int k = 0; k < WIN_CNT; k++) begin
			v[k] = img[(row + k / WIN_SIZE) * IMG_DIM + col + k % WIN_SIZE];
		end
		for (int i = 1; i < WIN_CNT; i++) begin
			t = v[i];
			j = i;
			while (j > 0 && v[j-1] > t) begin
				v[j] = v[j-1];
				j--;
			end
			v[j] = t;
		end
		return v[WIN_CNT / 2];
	endfunction

	task automatic push_expected();
		for (int r = 0; r < OUT_DIM; r++) begin
			for (int c = 0; c < OUT_DIM; c++) begin
				exp_mem[wr_ptr] = ref_median(r, c);
				wr_ptr++;
			end
		end
	endtask

	task automatic fill_random();
		for (int i = 0; i < PIX_CNT; i++) begin
			img[i] = PIX_W'(random_bits(PIX_W));
		end
	endtask

	// bright dots four apart, so a window sees one at most
	task automatic fill_impulse(input logic [PIX_W-1:0] peak);
		for (int r = 0; r < IMG_DIM; r++) begin
			for (int c = 0; c < IMG_DIM; c++) begin
				img[r * IMG_DIM + c] = (r % 4 == 1 && c % 4 == 1) ? peak : background;
			end
		end
	endtask

	// returns on a falling edge with load_ready high
	task automatic wait_ready(input bit garbage);
		int n;
		n = 0;
		@(negedge clk);
		while (!load_ready) begin
			if (n == WAIT_LIMIT) begin
				$display("timeout: load_ready stayed low for %0d cycles in %s", n, test_name);
				run_ok = 0;
				pixel_valid = 1'b0;
				return;
			end
			pixel_valid = garbage; // offered beats must be dropped
			load_end = 1'b0;
			{pixel_in4, pixel_in3, pixel_in2, pixel_in1, pixel_in0} =
				(LOAD_LANES * PIX_W)'(random_bits(LOAD_LANES * PIX_W));
			n++;
			@(negedge clk);
		end
		pixel_valid = 1'b0;
	endtask

	task automatic send_frame();
		int beat;
		beat = 0;
		while (beat < BEATS) begin
			if (random_bits(3) == 0) begin
				pixel_valid = 1'b0; // idle cycle now and then
				load_end = 1'b0;
			end else begin
				pixel_valid = 1'b1;
				load_end = (beat == BEATS - 1);
				pixel_in0 = img[beat * LOAD_LANES];
				pixel_in1 = img[beat * LOAD_LANES + 1];
				pixel_in2 = img[beat * LOAD_LANES + 2];
				pixel_in3 = img[beat * LOAD_LANES + 3];
				pixel_in4 = img[beat * LOAD_LANES + 4];
				beat++;
			end
			@(negedge clk);
		end
		pixel_valid = 1'b0;
		load_end = 1'b0;
		frames_sent++;
	endtask

	task automatic wait_done();
		int n;
		n = 0;
		while (done_cnt < frames_sent) begin
			if (n == WAIT_LIMIT) begin
				$display("timeout: frame_done missing after %0d cycles in %s", n, test_name);
				run_ok = 0;
				return;
			end
			n++;
			@(negedge clk);
		end
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_start_errs = err_cnt;
	endtask

	task automatic end_test();
		assert (rd_ptr == wr_ptr) else begin
			$display("FAIL %s results expected %0d actual %0d", test_name, wr_ptr, rd_ptr);
			err_cnt++;
		end
		assert (done_cnt == frames_sent) else begin
			$display("FAIL %s frame_done pulses expected %0d actual %0d", test_name,
				frames_sent, done_cnt);
			err_cnt++;
		end
		tests_run++;
		if (err_cnt == test_start_errs) begin
			$display("test %s passed", test_name);
		end else begin
			$display("test %s failed with %0d errors", test_name, err_cnt - test_start_errs);
			tests_failed++;
		end
	endtask

	task automatic run_tests();
		begin_test("reset_state");
		repeat (16) @(negedge clk);
		reset = 1'b0;
		repeat (2) @(negedge clk);
		end_test();

		begin_test("random_frame");
		fill_random();
		push_expected();
		wait_ready(1'b0);
		if (!run_ok) return;
		send_frame();
		wait_done();
		if (!run_ok) return;
		end_test();

		begin_test("impulse_frame");
		background = PIX_W'(random_bits(PIX_W - 1)); // keeps the peak strictly brighter
		fill_impulse({PIX_W{1'b1}});
		push_expected();
		wait_ready(1'b0);
		if (!run_ok) return;
		flat_check = 1'b1;
		send_frame();
		wait_done();
		flat_check = 1'b0;
		if (!run_ok) return;
		end_test();

		begin_test("back_to_back");
		fill_random();
		push_expected();
		wait_ready(1'b0);
		if (!run_ok) return;
		send_frame();
		fill_random();
		push_expected();
		wait_ready(1'b1); // junk beats while the first frame scans
		if (!run_ok) return;
		send_frame();
		wait_done();
		if (!run_ok) return;
		end_test();
	endtask

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		pixel_in0 = '0;
		pixel_in1 = '0;
		pixel_in2 = '0;
		pixel_in3 = '0;
		pixel_in4 = '0;
		pixel_valid = 1'b0;
		load_end = 1'b0;
		lfsr = 32'h80eee258;
		background = '0;
		wr_ptr = 0;
		frames_sent = 0;
		err_cnt = 0;
		test_start_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		run_ok = 1'b1;
		flat_check = 1'b0;
		test_name = "none";
		run_tests();
		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			err_cnt);
		if (run_ok && err_cnt == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

/* tb.f */
rtl/image_pkg.sv
rtl/scan_pkg.sv
rtl/frame_buffer.sv
rtl/window_scanner.sv
rtl/column_sorter.sv
rtl/median_merge.sv
rtl/image_median_top.sv
verification/tb_image_median_top.sv

/* Makefile */
# Verilator build for the 3x3 median filter testbench

VERILATOR ?= verilator
TOP := tb_image_median_top
RTL_TOP := image_median_top
FILE_LIST := tb.f
BUILD_DIR := obj_dir
LOG := sim.log
LINT_FLAGS := --lint-only --timing
SIM_FLAGS := --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "simulation reported failure"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
